/* hdl/cam_pkg.sv */
`default_nettype none

package cam_pkg;

	localparam int L2_AWIDTH = 12;
	localparam int TRANS_SIZE = 16;
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

	typedef enum logic [4:0] {
		REG_RX_SADDR   = 5'h00,
		REG_RX_SIZE    = 5'h01,
		REG_RX_CFG     = 5'h02,
		REG_CAM_CFG    = 5'h08,
		REG_CAM_LL     = 5'h09,
		REG_CAM_UR     = 5'h0A,
		REG_CAM_SIZE   = 5'h0B,
		REG_CAM_FILTER = 5'h0C,
		REG_CAM_VSYNC  = 5'h0D
	} cam_reg_e;

	// Bytes packed into one memory beat.
	typedef enum logic [1:0] {
		DS_BYTE = 2'd0,
		DS_HALF = 2'd1,
		DS_WORD = 2'd2
	} datasize_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_RUN,
		RX_DRAIN
	} rx_state_e;

	typedef struct packed {
		logic [L2_AWIDTH-1:0]  startaddr;
		logic [TRANS_SIZE-1:0] size;
		datasize_e             datasize;
		logic                  continuous;
	} rx_cfg_t;

	// Window corners are in pixels, x is the column and y the row.
	typedef struct packed {
		logic        enable;
		logic        window_en;
		logic [15:0] ll_x;
		logic [15:0] ll_y;
		logic [15:0] ur_x;
		logic [15:0] ur_y;
		logic [15:0] row_len;
		logic [7:0]  gain;
		logic        vsync_pol;
	} cam_cfg_t;

endpackage

`default_nettype wire

/* hdl/cam_stream_if.sv */
`default_nettype none

// Pixel stream with credit return from the frame processor to the receive channel.
interface cam_stream_if;

	logic       pix_valid;
	logic [7:0] pix_data;
	logic       sof;
	logic       credit_ret;
	logic       flush;

	modport source (
		output pix_valid,
		output pix_data,
		output sof,
		input  credit_ret,
		input  flush
	);

	modport sink (
		input  pix_valid,
		input  pix_data,
		input  sof,
		output credit_ret,
		output flush
	);

endinterface

`default_nettype wire

/* hdl/cam_reg_if.sv */
`default_nettype none

module cam_reg_if import cam_pkg::*; (
	input  wire                  clk_i,
	input  wire                  rstn_i,
	input  wire [31:0]           cfg_data_i,
	input  wire [4:0]            cfg_addr_i,
	input  wire                  cfg_valid_i,
	input  wire                  cfg_rwn_i,
	output logic [31:0]          cfg_data_o,
	output logic                 cfg_ready_o,
	output rx_cfg_t              rx_cfg_o,
	output logic                 rx_en_o,
	output logic                 rx_clr_o,
	input  wire                  rx_busy_i,
	input  wire                  rx_pending_i,
	input  wire [L2_AWIDTH-1:0]  rx_curr_addr_i,
	input  wire [TRANS_SIZE-1:0] rx_bytes_left_i,
	output cam_cfg_t             cam_cfg_o,
	input  wire                  cam_active_i,
	input  wire                  overflow_i
);

	logic                  wr_en;
	logic                  rd_en;
	logic [L2_AWIDTH-1:0]  saddr_q;
	logic [TRANS_SIZE-1:0] size_q;
	datasize_e             datasize_q;
	logic                  continuous_q;
	logic                  rx_en_q;
	logic                  rx_clr_q;
	logic [31:0]           cam_cfg_q;
	logic [31:0]           cam_ll_q;
	logic [31:0]           cam_ur_q;
	logic [15:0]           cam_size_q;
	logic [7:0]            cam_filter_q;
	logic                  vsync_pol_q;

	assign wr_en = cfg_valid_i & ~cfg_rwn_i;
	assign rd_en = cfg_valid_i & cfg_rwn_i;

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			saddr_q      <= '0;
			size_q       <= '0;
			datasize_q   <= DS_BYTE;
			continuous_q <= 1'b0;
			rx_en_q      <= 1'b0;
			rx_clr_q     <= 1'b0;
			cam_cfg_q    <= '0;
			cam_ll_q     <= '0;
			cam_ur_q     <= '0;
			cam_size_q   <= '0;
			cam_filter_q <= '0;
			vsync_pol_q  <= 1'b0;
		end else begin
			// Enable and clear are strobes and fall back on their own.
			rx_en_q  <= 1'b0;
			rx_clr_q <= 1'b0;
			if (wr_en) begin
				case (cam_reg_e'(cfg_addr_i))
					REG_RX_SADDR:   saddr_q <= cfg_data_i[L2_AWIDTH-1:0];
					REG_RX_SIZE:    size_q <= cfg_data_i[TRANS_SIZE-1:0];
					REG_RX_CFG: begin
						rx_clr_q     <= cfg_data_i[6];
						rx_en_q      <= cfg_data_i[4];
						datasize_q   <= datasize_e'(cfg_data_i[2:1]);
						continuous_q <= cfg_data_i[0];
					end
					REG_CAM_CFG:    cam_cfg_q <= cfg_data_i;
					REG_CAM_LL:     cam_ll_q <= cfg_data_i;
					REG_CAM_UR:     cam_ur_q <= cfg_data_i;
					REG_CAM_SIZE:   cam_size_q <= cfg_data_i[15:0];
					REG_CAM_FILTER: cam_filter_q <= cfg_data_i[7:0];
					REG_CAM_VSYNC:  vsync_pol_q <= cfg_data_i[0];
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		cfg_data_o = '0;
		if (rd_en) begin
			case (cam_reg_e'(cfg_addr_i))
				REG_RX_SADDR:   cfg_data_o[L2_AWIDTH-1:0] = rx_curr_addr_i;
				REG_RX_SIZE:    cfg_data_o[TRANS_SIZE-1:0] = rx_bytes_left_i;
				REG_RX_CFG: begin
					cfg_data_o[5:0] = {rx_pending_i, rx_busy_i, overflow_i,
						datasize_q, continuous_q};
				end
				REG_CAM_CFG:    cfg_data_o = {cam_active_i, cam_cfg_q[30:0]};
				REG_CAM_LL:     cfg_data_o = cam_ll_q;
				REG_CAM_UR:     cfg_data_o = cam_ur_q;
				REG_CAM_SIZE:   cfg_data_o[15:0] = cam_size_q;
				REG_CAM_FILTER: cfg_data_o[7:0] = cam_filter_q;
				REG_CAM_VSYNC:  cfg_data_o[0] = vsync_pol_q;
				default:        cfg_data_o = '0;
			endcase
		end
	end

	assign cfg_ready_o = 1'b1;
	assign rx_en_o = rx_en_q;
	assign rx_clr_o = rx_clr_q;

	assign rx_cfg_o = '{
		startaddr:  saddr_q,
		size:       size_q,
		datasize:   datasize_q,
		continuous: continuous_q
	};

	// Corners pack x in the low half and y in the high half.
	assign cam_cfg_o = '{
		enable:    cam_cfg_q[31],
		window_en: cam_cfg_q[0],
		ll_x:      cam_ll_q[15:0],
		ll_y:      cam_ll_q[31:16],
		ur_x:      cam_ur_q[15:0],
		ur_y:      cam_ur_q[31:16],
		row_len:   cam_size_q,
		gain:      cam_filter_q,
		vsync_pol: vsync_pol_q
	};

	a_en_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
		rx_en_o |=> !rx_en_o);
	a_clr_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
		rx_clr_o |=> !rx_clr_o);

endmodule

`default_nettype wire

/* hdl/cam_frame_proc.sv */
`default_nettype none

module cam_frame_proc import cam_pkg::*; (
	input  wire           clk_i,
	input  wire           rstn_i,
	input  wire cam_cfg_t cam_cfg_i,
	input  wire           cam_vsync_i,
	input  wire           cam_valid_i,
	input  wire [7:0]     cam_data_i,
	input  wire           clr_i,
	output logic          cam_active_o,
	output logic          overflow_o,
	cam_stream_if.source  stream
);

	logic                vsync_corr;
	logic                vsync_q;
	logic                frame_start;
	logic [15:0]         col_q;
	logic [15:0]         row_q;
	logic                in_window;
	logic                accept;
	logic                has_credit;
	logic                push;
	logic [15:0]         product;
	logic [7:0]          pix_sat;
	logic [CREDIT_W-1:0] credits_q;
	logic                sof_pend_q;

	assign vsync_corr = cam_vsync_i ^ cam_cfg_i.vsync_pol;
	assign frame_start = vsync_corr & ~vsync_q;

	// The window is inclusive on all four edges.
	assign in_window = ~cam_cfg_i.window_en |
		((col_q >= cam_cfg_i.ll_x) & (col_q <= cam_cfg_i.ur_x) &
		 (row_q >= cam_cfg_i.ll_y) & (row_q <= cam_cfg_i.ur_y));

	assign accept = cam_active_o & cam_valid_i & ~frame_start & in_window;
	assign has_credit = credits_q != '0;
	assign push = accept & has_credit;

	// Gain is Q4.4, so 0x10 passes the pixel through unchanged.
	assign product = cam_data_i * cam_cfg_i.gain;
	assign pix_sat = (|product[15:12]) ? 8'hFF : product[11:4];

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			vsync_q      <= 1'b0;
			cam_active_o <= 1'b0;
			col_q        <= '0;
			row_q        <= '0;
			sof_pend_q   <= 1'b0;
		end else begin
			vsync_q <= vsync_corr;
			if (frame_start) begin
				cam_active_o <= cam_cfg_i.enable;
				col_q        <= '0;
				row_q        <= '0;
				sof_pend_q   <= 1'b1;
			end else begin
				if (cam_active_o && cam_valid_i) begin
					if (col_q == cam_cfg_i.row_len - 16'd1) begin
						col_q <= '0;
						row_q <= row_q + 16'd1;
					end else begin
						col_q <= col_q + 16'd1;
					end
				end
				if (push)
					sof_pend_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			credits_q  <= CREDIT_W'(FIFO_DEPTH);
			overflow_o <= 1'b0;
		end else begin
			// A pixel spent during the flush cycle lands in the emptied FIFO.
			if (stream.flush)
				credits_q <= CREDIT_W'(FIFO_DEPTH) - CREDIT_W'(push);
			else
				credits_q <= credits_q - CREDIT_W'(push) + CREDIT_W'(stream.credit_ret);
			if (clr_i)
				overflow_o <= 1'b0;
			else if (accept && !has_credit)
				overflow_o <= 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			stream.pix_valid <= 1'b0;
			stream.sof       <= 1'b0;
		end else begin
			stream.pix_valid <= push;
			stream.sof       <= push & sof_pend_q;
		end
	end

	always_ff @(posedge clk_i) begin
		if (push)
			stream.pix_data <= pix_sat;
	end

	a_credit_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
		credits_q <= CREDIT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

/* hdl/cam_rx_channel.sv */
`default_nettype none

module cam_rx_channel import cam_pkg::*; (
	input  wire                   clk_i,
	input  wire                   rstn_i,
	input  wire rx_cfg_t          rx_cfg_i,
	input  wire                   en_i,
	input  wire                   clr_i,
	cam_stream_if.sink            stream,
	output logic                  busy_o,
	output logic                  pending_o,
	output logic [L2_AWIDTH-1:0]  curr_addr_o,
	output logic [TRANS_SIZE-1:0] bytes_left_o,
	output logic                  mem_req_o,
	output logic [L2_AWIDTH-1:0]  mem_addr_o,
	output logic [31:0]           mem_wdata_o,
	output logic [3:0]            mem_be_o,
	input  wire                   mem_gnt_i
);

	rx_state_e             state_q;
	logic [8:0]            fifo_mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr_q;
	logic [FIFO_PTR_W-1:0] rd_ptr_q;
	logic [CREDIT_W-1:0]   fifo_cnt_q;
	logic                  fifo_empty;
	logic                  fifo_full;
	logic                  push;
	logic                  pop;
	logic [8:0]            pop_entry;
	logic [1:0]            pop_lane;
	logic [1:0]            pack_cnt_q;
	logic [31:0]           pack_data_q;
	logic                  beat_done;
	logic                  req_q;
	logic                  grant;
	logic                  last_beat;
	logic                  pending_q;
	logic [L2_AWIDTH-1:0]  addr_q;
	logic [TRANS_SIZE-1:0] bytes_left_q;
	logic [2:0]            beat_bytes;
	logic [3:0]            be_base;

	always_comb begin
		case (rx_cfg_i.datasize)
			DS_BYTE: begin
				beat_bytes = 3'd1;
				be_base    = 4'b0001;
			end
			DS_HALF: begin
				beat_bytes = 3'd2;
				be_base    = 4'b0011;
			end
			default: begin
				beat_bytes = 3'd4;
				be_base    = 4'b1111;
			end
		endcase
	end

	assign fifo_empty = fifo_cnt_q == '0;
	assign fifo_full = fifo_cnt_q == CREDIT_W'(FIFO_DEPTH);
	assign push = stream.pix_valid & ~clr_i;

	// While idle the FIFO is drained so that credits keep flowing.
	assign pop = ~clr_i & ~fifo_empty &
		((state_q == RX_IDLE) | ((state_q == RX_RUN) & ~req_q));
	assign pop_entry = fifo_mem[rd_ptr_q];

	// A frame start restarts packing at lane 0.
	assign pop_lane = pop_entry[8] ? 2'd0 : pack_cnt_q;
	assign beat_done = {1'b0, pop_lane} == beat_bytes - 3'd1;

	assign grant = req_q & mem_gnt_i;
	assign last_beat = bytes_left_q <= TRANS_SIZE'(beat_bytes);

	assign stream.credit_ret = pop;
	assign stream.flush = clr_i;

	always_ff @(posedge clk_i) begin
		if (push)
			fifo_mem[wr_ptr_q] <= {stream.sof, stream.pix_data};
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			fifo_cnt_q <= '0;
		end else if (clr_i) begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			fifo_cnt_q <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			fifo_cnt_q <= fifo_cnt_q + CREDIT_W'(push) - CREDIT_W'(pop);
		end
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			state_q      <= RX_IDLE;
			req_q        <= 1'b0;
			pending_q    <= 1'b0;
			pack_cnt_q   <= '0;
			addr_q       <= '0;
			bytes_left_q <= '0;
		end else if (clr_i) begin
			state_q    <= RX_IDLE;
			req_q      <= 1'b0;
			pending_q  <= 1'b0;
			pack_cnt_q <= '0;
		end else begin
			if (en_i && state_q != RX_IDLE)
				pending_q <= 1'b1;
			case (state_q)
				RX_IDLE: begin
					if (en_i) begin
						addr_q       <= rx_cfg_i.startaddr;
						bytes_left_q <= rx_cfg_i.size;
						pack_cnt_q   <= '0;
						state_q      <= RX_RUN;
					end
				end
				RX_RUN: begin
					if (pop) begin
						pack_cnt_q <= beat_done ? 2'd0 : pop_lane + 2'd1;
						if (beat_done)
							req_q <= 1'b1;
					end
					if (grant) begin
						req_q  <= 1'b0;
						addr_q <= addr_q + L2_AWIDTH'(beat_bytes);
						if (last_beat) begin
							bytes_left_q <= '0;
							state_q      <= RX_DRAIN;
						end else begin
							bytes_left_q <= bytes_left_q - TRANS_SIZE'(beat_bytes);
						end
					end
				end
				RX_DRAIN: begin
					if (rx_cfg_i.continuous || pending_q) begin
						addr_q       <= rx_cfg_i.startaddr;
						bytes_left_q <= rx_cfg_i.size;
						pending_q    <= 1'b0;
						state_q      <= RX_RUN;
					end else begin
						state_q <= RX_IDLE;
					end
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (pop && state_q == RX_RUN)
			pack_data_q[8*pop_lane +: 8] <= pop_entry[7:0];
	end

	assign busy_o = state_q != RX_IDLE;
	assign pending_o = pending_q;
	assign curr_addr_o = addr_q;
	assign bytes_left_o = bytes_left_q;

	// Beats go out on the byte lanes selected by the low address bits.
	assign mem_req_o = req_q;
	assign mem_addr_o = addr_q;
	assign mem_be_o = be_base << addr_q[1:0];
	assign mem_wdata_o = pack_data_q << {addr_q[1:0], 3'b000};

	a_no_push_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
		!(push && fifo_full));
	a_addr_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
		mem_req_o && !mem_gnt_i && !clr_i |=> mem_req_o && $stable(mem_addr_o));

endmodule

`default_nettype wire

/* hdl/cam_subsys_top.sv */
`default_nettype none

module cam_subsys_top import cam_pkg::*; (
	input  wire                  clk_i,
	input  wire                  rstn_i,
	input  wire [31:0]           cfg_data_i,
	input  wire [4:0]            cfg_addr_i,
	input  wire                  cfg_valid_i,
	input  wire                  cfg_rwn_i,
	output logic [31:0]          cfg_data_o,
	output logic                 cfg_ready_o,
	input  wire                  cam_vsync_i,
	input  wire                  cam_valid_i,
	input  wire [7:0]            cam_data_i,
	output logic                 mem_req_o,
	output logic [L2_AWIDTH-1:0] mem_addr_o,
	output logic [31:0]          mem_wdata_o,
	output logic [3:0]           mem_be_o,
	input  wire                  mem_gnt_i
);

	rx_cfg_t               rx_cfg;
	cam_cfg_t              cam_cfg;
	logic                  rx_en;
	logic                  rx_clr;
	logic                  rx_busy;
	logic                  rx_pending;
	logic [L2_AWIDTH-1:0]  rx_curr_addr;
	logic [TRANS_SIZE-1:0] rx_bytes_left;
	logic                  cam_active;
	logic                  overflow;

	cam_stream_if stream_if ();

	cam_reg_if u_reg_if (
		.clk_i           (clk_i),
		.rstn_i          (rstn_i),
		.cfg_data_i      (cfg_data_i),
		.cfg_addr_i      (cfg_addr_i),
		.cfg_valid_i     (cfg_valid_i),
		.cfg_rwn_i       (cfg_rwn_i),
		.cfg_data_o      (cfg_data_o),
		.cfg_ready_o     (cfg_ready_o),
		.rx_cfg_o        (rx_cfg),
		.rx_en_o         (rx_en),
		.rx_clr_o        (rx_clr),
		.rx_busy_i       (rx_busy),
		.rx_pending_i    (rx_pending),
		.rx_curr_addr_i  (rx_curr_addr),
		.rx_bytes_left_i (rx_bytes_left),
		.cam_cfg_o       (cam_cfg),
		.cam_active_i    (cam_active),
		.overflow_i      (overflow)
	);

	cam_frame_proc u_frame_proc (
		.clk_i        (clk_i),
		.rstn_i       (rstn_i),
		.cam_cfg_i    (cam_cfg),
		.cam_vsync_i  (cam_vsync_i),
		.cam_valid_i  (cam_valid_i),
		.cam_data_i   (cam_data_i),
		.clr_i        (rx_clr),
		.cam_active_o (cam_active),
		.overflow_o   (overflow),
		.stream       (stream_if.source)
	);

	cam_rx_channel u_rx_channel (
		.clk_i        (clk_i),
		.rstn_i       (rstn_i),
		.rx_cfg_i     (rx_cfg),
		.en_i         (rx_en),
		.clr_i        (rx_clr),
		.stream       (stream_if.sink),
		.busy_o       (rx_busy),
		.pending_o    (rx_pending),
		.curr_addr_o  (rx_curr_addr),
		.bytes_left_o (rx_bytes_left),
		.mem_req_o    (mem_req_o),
		.mem_addr_o   (mem_addr_o),
		.mem_wdata_o  (mem_wdata_o),
		.mem_be_o     (mem_be_o),
		.mem_gnt_i    (mem_gnt_i)
	);

endmodule

`default_nettype wire

/* dv/cam_tb.sv */
`default_nettype none

module cam_tb import cam_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic                  clk_i;
	logic                  rstn_i;
	logic [31:0]           cfg_data_i;
	logic [4:0]            cfg_addr_i;
	logic                  cfg_valid_i;
	logic                  cfg_rwn_i;
	logic [31:0]           cfg_data_o;
	logic                  cfg_ready_o;
	logic                  cam_vsync_i;
	logic                  cam_valid_i;
	logic [7:0]            cam_data_i;
	logic                  mem_req_o;
	logic [L2_AWIDTH-1:0]  mem_addr_o;
	logic [31:0]           mem_wdata_o;
	logic [3:0]            mem_be_o;
	logic                  mem_gnt_i;

	logic [7:0]  mem [1 << L2_AWIDTH];
	logic [7:0]  pix_q [$];
	logic        vsync_pol;
	int          gnt_delay;
	int          wait_cnt;
	int          write_cnt;
	int          multi_be_cnt;
	int          errors;
	int          tests;
	logic [31:0] rd;

	cam_subsys_top dut (
		.clk_i       (clk_i),
		.rstn_i      (rstn_i),
		.cfg_data_i  (cfg_data_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_valid_i (cfg_valid_i),
		.cfg_rwn_i   (cfg_rwn_i),
		.cfg_data_o  (cfg_data_o),
		.cfg_ready_o (cfg_ready_o),
		.cam_vsync_i (cam_vsync_i),
		.cam_valid_i (cam_valid_i),
		.cam_data_i  (cam_data_i),
		.mem_req_o   (mem_req_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_be_o    (mem_be_o),
		.mem_gnt_i   (mem_gnt_i)
	);

	always #50 clk_i = ~clk_i;

	// L2 model. The grant is raised on a falling edge, so the write lands on the next rising edge.
	always @(negedge clk_i) begin
		if (mem_gnt_i) begin
			mem_gnt_i = 1'b0;
			wait_cnt = 0;
		end else if (rstn_i && mem_req_o) begin
			if (wait_cnt >= gnt_delay) begin
				for (int l = 0; l < 4; l++) begin
					if (mem_be_o[l])
						mem[{mem_addr_o[L2_AWIDTH-1:2], 2'b00} + l] = mem_wdata_o[8*l +: 8];
				end
				if ($countones(mem_be_o) != 1)
					multi_be_cnt++;
				write_cnt++;
				mem_gnt_i = 1'b1;
			end else begin
				wait_cnt++;
			end
		end else begin
			wait_cnt = 0;
		end
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input logic [L2_AWIDTH-1:0] got,
			input logic [L2_AWIDTH-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bytes(input string name, input logic [TRANS_SIZE-1:0] got,
			input logic [TRANS_SIZE-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic write_reg(input cam_reg_e addr, input logic [31:0] data);
		@(negedge clk_i);
		cfg_valid_i = 1'b1;
		cfg_rwn_i = 1'b0;
		cfg_addr_i = addr;
		cfg_data_i = data;
		@(negedge clk_i);
		cfg_valid_i = 1'b0;
	endtask

	task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
		@(negedge clk_i);
		cfg_valid_i = 1'b1;
		cfg_rwn_i = 1'b1;
		cfg_addr_i = addr;
		#10;
		data = cfg_data_o;
		@(negedge clk_i);
		cfg_valid_i = 1'b0;
	endtask

	task automatic fill_mem();
		for (int a = 0; a < (1 << L2_AWIDTH); a++)
			mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5C;
		write_cnt = 0;
		multi_be_cnt = 0;
	endtask

	task automatic pulse_vsync();
		@(negedge clk_i);
		cam_vsync_i = ~vsync_pol;
		repeat (2) @(negedge clk_i);
		cam_vsync_i = vsync_pol;
		@(negedge clk_i);
	endtask

	task automatic send_pixels(input int n, input int gap);
		pix_q.delete();
		for (int i = 0; i < n; i++) begin
			pix_q.push_back(8'($urandom));
			@(negedge clk_i);
			cam_valid_i = 1'b1;
			cam_data_i = pix_q[i];
			repeat (gap - 1) begin
				@(negedge clk_i);
				cam_valid_i = 1'b0;
			end
		end
		@(negedge clk_i);
		cam_valid_i = 1'b0;
	endtask

	task automatic setup_camera(input logic [15:0] row_len, input logic win_en,
			input logic [31:0] ll, input logic [31:0] ur, input logic [7:0] gain);
		write_reg(REG_CAM_SIZE, {16'h0, row_len});
		write_reg(REG_CAM_LL, ll);
		write_reg(REG_CAM_UR, ur);
		write_reg(REG_CAM_FILTER, {24'h0, gain});
		write_reg(REG_CAM_CFG, {1'b1, 30'h0, win_en});
	endtask

	task automatic start_capture(input logic [11:0] saddr, input logic [15:0] size,
			input datasize_e ds, input logic cont);
		write_reg(REG_RX_CFG, 32'h40);
		write_reg(REG_RX_SADDR, {20'h0, saddr});
		write_reg(REG_RX_SIZE, {16'h0, size});
		write_reg(REG_RX_CFG, {26'h0, 1'b0, 1'b1, 1'b0, ds, cont});
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		read_reg(REG_RX_CFG, rd);
		while (rd[4]) begin
			if (n == limit)
				abort_run("Timeout waiting for the receive channel to go idle.");
			n++;
			read_reg(REG_RX_CFG, rd);
		end
	endtask

	task automatic wait_writes(input int count, input int limit);
		int n;
		n = 0;
		while (write_cnt < count) begin
			if (n == limit)
				abort_run("Timeout waiting for memory writes.");
			n++;
			@(negedge clk_i);
		end
	endtask

	task automatic report(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("%s: passed", name);
		else
			$display("%s: %0d errors", name, errors - err_before);
	endtask

	task automatic test_registers();
		int e;
		e = errors;
		check_bit("cfg_ready_o", cfg_ready_o, 1'b1);
		write_reg(REG_CAM_LL, 32'h1234_5678);
		read_reg(REG_CAM_LL, rd);
		check_word("cam_ll", rd, 32'h1234_5678);
		write_reg(REG_CAM_UR, 32'h9ABC_DEF0);
		read_reg(REG_CAM_UR, rd);
		check_word("cam_ur", rd, 32'h9ABC_DEF0);
		write_reg(REG_CAM_SIZE, 32'hFFFF_FFFF);
		read_reg(REG_CAM_SIZE, rd);
		check_word("cam_size", rd, 32'h0000_FFFF);
		write_reg(REG_CAM_FILTER, 32'hFFFF_FFFF);
		read_reg(REG_CAM_FILTER, rd);
		check_word("cam_filter", rd, 32'h0000_00FF);
		// No vsync edge yet, so bit 31 shows the inactive camera.
		write_reg(REG_CAM_CFG, 32'hDEAD_BEEF);
		read_reg(REG_CAM_CFG, rd);
		check_word("cam_cfg", rd, 32'h5EAD_BEEF);
		write_reg(REG_CAM_CFG, 32'h0);
		write_reg(REG_CAM_VSYNC, 32'hFFFF_FFFF);
		read_reg(REG_CAM_VSYNC, rd);
		check_word("cam_vsync", rd, 32'h1);
		write_reg(REG_CAM_VSYNC, 32'h0);
		write_reg(REG_RX_CFG, 32'h5);
		read_reg(REG_RX_CFG, rd);
		check_word("rx_cfg", rd, 32'h5);
		write_reg(REG_RX_CFG, 32'h4);
		read_reg(5'h05, rd);
		check_word("unused", rd, 32'h0);
		report("register readback", e);
	endtask

	task automatic test_straight();
		int e;
		e = errors;
		fill_mem();
		setup_camera(16'd16, 1'b0, 32'h0, 32'h0, 8'h10);
		pulse_vsync();
		start_capture(12'h100, 16'd16, DS_WORD, 1'b0);
		send_pixels(16, 3);
		wait_idle(200);
		for (int i = 0; i < 16; i++)
			check_word($sformatf("mem[%0d]", i), {24'h0, mem[12'h100 + i]}, {24'h0, pix_q[i]});
		read_reg(REG_RX_SIZE, rd);
		check_bytes("bytes_left", rd[15:0], 16'd0);
		read_reg(REG_RX_SADDR, rd);
		check_addr("curr_addr", rd[11:0], 12'h110);
		report("straight capture", e);
	endtask

	task automatic test_window();
		int e;
		int k;
		int px;
		e = errors;
		fill_mem();
		// Columns 2 to 4 and rows 1 to 3.
		setup_camera(16'd8, 1'b1, {16'd1, 16'd2}, {16'd3, 16'd4}, 8'h18);
		pulse_vsync();
		start_capture(12'h200, 16'd9, DS_BYTE, 1'b0);
		send_pixels(40, 3);
		wait_idle(200);
		k = 0;
		for (int i = 0; i < 40; i++) begin
			if (i / 8 >= 1 && i / 8 <= 3 && i % 8 >= 2 && i % 8 <= 4) begin
				px = (int'(pix_q[i]) * 24) >> 4;
				if (px > 255)
					px = 255;
				check_word($sformatf("mem[%0d]", k), {24'h0, mem[12'h200 + k]}, 32'(px));
				k++;
			end
		end
		check_word("beats", 32'(write_cnt), 32'd9);
		check_bit("multi_be", multi_be_cnt != 0, 1'b0);
		report("window and gain", e);
	endtask

	task automatic test_vsync();
		int e;
		e = errors;
		fill_mem();
		write_reg(REG_CAM_CFG, 32'h0);
		write_reg(REG_CAM_FILTER, 32'h10);
		write_reg(REG_CAM_SIZE, 32'd16);
		pulse_vsync();
		@(negedge clk_i);
		cam_vsync_i = 1'b1;
		write_reg(REG_CAM_VSYNC, 32'h1);
		vsync_pol = 1'b1;
		write_reg(REG_CAM_CFG, 32'h8000_0000);
		read_reg(REG_CAM_CFG, rd);
		check_bit("cam_active", rd[31], 1'b0);
		start_capture(12'h300, 16'd4, DS_BYTE, 1'b0);
		send_pixels(4, 3);
		// The frame must start on the falling edge, before vsync returns high.
		@(negedge clk_i);
		cam_vsync_i = 1'b0;
		read_reg(REG_CAM_CFG, rd);
		check_bit("cam_active", rd[31], 1'b1);
		cam_vsync_i = 1'b1;
		send_pixels(4, 3);
		wait_idle(200);
		for (int i = 0; i < 4; i++)
			check_word($sformatf("mem[%0d]", i), {24'h0, mem[12'h300 + i]}, {24'h0, pix_q[i]});
		check_word("beats", 32'(write_cnt), 32'd4);
		write_reg(REG_CAM_VSYNC, 32'h0);
		vsync_pol = 1'b0;
		@(negedge clk_i);
		cam_vsync_i = 1'b0;
		report("vsync polarity", e);
	endtask

	task automatic test_overflow();
		int e;
		e = errors;
		fill_mem();
		gnt_delay = 1000;
		setup_camera(16'd16, 1'b0, 32'h0, 32'h0, 8'h10);
		pulse_vsync();
		start_capture(12'h500, 16'd16, DS_BYTE, 1'b0);
		send_pixels(12, 1);
		read_reg(REG_RX_CFG, rd);
		check_bit("overflow", rd[3], 1'b1);
		check_bit("busy", rd[4], 1'b1);
		write_reg(REG_RX_CFG, 32'h40);
		read_reg(REG_RX_CFG, rd);
		check_bit("overflow", rd[3], 1'b0);
		check_bit("busy", rd[4], 1'b0);
		check_bit("mem_req_o", mem_req_o, 1'b0);
		gnt_delay = 0;
		report("back-pressure", e);
	endtask

	task automatic test_continuous(input datasize_e ds, input string name);
		int e;
		e = errors;
		fill_mem();
		setup_camera(16'd16, 1'b0, 32'h0, 32'h0, 8'h10);
		pulse_vsync();
		start_capture(12'h400, 16'd4, ds, 1'b1);
		// A second enable while busy leaves a pending restart.
		write_reg(REG_RX_CFG, {26'h0, 1'b0, 1'b1, 1'b0, ds, 1'b1});
		read_reg(REG_RX_CFG, rd);
		check_bit("pending", rd[5], 1'b1);
		send_pixels(8, 3);
		wait_writes(ds == DS_BYTE ? 8 : 4, 200);
		for (int i = 0; i < 4; i++)
			check_word($sformatf("mem[%0d]", i), {24'h0, mem[12'h400 + i]},
				{24'h0, pix_q[4 + i]});
		check_word("mem[4]", {24'h0, mem[12'h404]}, 32'h5C ^ 32'h04 ^ 32'h04);
		write_reg(REG_RX_CFG, 32'h40);
		report(name, e);
	endtask

	initial begin
		#5_000_000;
		abort_run("Simulation time limit reached.");
	end

	initial begin
		clk_i = 1'b0;
		rstn_i = 1'b0;
		cfg_data_i = '0;
		cfg_addr_i = '0;
		cfg_valid_i = 1'b0;
		cfg_rwn_i = 1'b1;
		cam_vsync_i = 1'b0;
		cam_valid_i = 1'b0;
		cam_data_i = '0;
		mem_gnt_i = 1'b0;
		vsync_pol = 1'b0;
		gnt_delay = 0;
		wait_cnt = 0;
		errors = 0;
		tests = 0;
		void'($urandom(32'h999d));
		fill_mem();
		repeat (8) @(posedge clk_i);
		@(negedge clk_i);
		rstn_i = 1'b1;
		test_registers();
		test_straight();
		test_window();
		test_vsync();
		test_overflow();
		test_continuous(DS_BYTE, "continuous bytes");
		test_continuous(DS_HALF, "continuous halfwords");
		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
hdl/cam_pkg.sv
hdl/cam_stream_if.sv
hdl/cam_reg_if.sv
hdl/cam_frame_proc.sv
hdl/cam_rx_channel.sv
hdl/cam_subsys_top.sv
dv/cam_tb.sv

/* run.sh */
#!/bin/sh
# Builds the camera subsystem testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module cam_tb \
	--Mdir obj_dir -o cam_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cam_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST OK" sim.log; then
	echo "No result found in sim.log"
	exit 1
fi
exit 0
